//--- hdl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath widths
`define DATA_WIDTH      32
`define INST_WIDTH      32
`define REG_ADDR_WIDTH  5

// instruction field widths
`define OPCODE_WIDTH    6
`define SHAMT_WIDTH     5
`define FUNCT_WIDTH     6
`define IMM_WIDTH       16

// word address widths of the two memories
`define IMEM_DEPTH_LOG2 8
`define DMEM_DEPTH_LOG2 8

// opcodes
`define OPCODE_R        6'h00
`define OPCODE_ADDI     6'h08
`define OPCODE_ORI      6'h0d
`define OPCODE_LW       6'h23
`define OPCODE_SW       6'h2b

// funct codes, register format only
`define FUNCT_SLL       6'h00
`define FUNCT_SRL       6'h02
`define FUNCT_ADD       6'h20
`define FUNCT_SUB       6'h22
`define FUNCT_AND       6'h24
`define FUNCT_OR        6'h25
`define FUNCT_XOR       6'h26
`define FUNCT_SLT       6'h2a

`endif

//--- hdl/cpu_pkg.sv
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

  // forwarding source for an execute operand
  localparam logic [1:0] FWD_REG    = 2'b00;
  localparam logic [1:0] FWD_MEM_WB = 2'b01;
  localparam logic [1:0] FWD_EX_MEM = 2'b10;

  typedef struct packed {
    logic [`OPCODE_WIDTH-1:0]   opcode;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`SHAMT_WIDTH-1:0]    shamt;
    logic [`FUNCT_WIDTH-1:0]    funct;
  } r_fmt_t;

  typedef struct packed {
    logic [`OPCODE_WIDTH-1:0]   opcode;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`IMM_WIDTH-1:0]      imm;
  } i_fmt_t;

  // same word, two views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    alu_src;
    logic    zero_ext;
    logic    dst_rd;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                      ctrl;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`REG_ADDR_WIDTH-1:0] dst;
    logic [`DATA_WIDTH-1:0]     rs_data;
    logic [`DATA_WIDTH-1:0]     rt_data;
    logic [`DATA_WIDTH-1:0]     imm;
    logic [`SHAMT_WIDTH-1:0]    shamt;
  } id_ex_t;

  typedef struct packed {
    ctrl_t                      ctrl;
    logic [`REG_ADDR_WIDTH-1:0] dst;
    logic [`DATA_WIDTH-1:0]     alu_result;
    logic [`DATA_WIDTH-1:0]     store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                       reg_write;
    logic [`REG_ADDR_WIDTH-1:0] dst;
    logic [`DATA_WIDTH-1:0]     wdata;
  } mem_wb_t;

endpackage

`default_nettype wire

//--- hdl/control_unit.sv
`default_nettype none

`include "cpu_consts.svh"

module control_unit import cpu_pkg::*; (
  input  instr_u instr,
  output ctrl_t  ctrl
);

  logic    funct_ok;
  alu_op_e r_op;

  // register format, funct picks the operation
  always_comb begin
    funct_ok = 1'b1;
    case (instr.r.funct)
      `FUNCT_ADD: r_op = ALU_ADD;
      `FUNCT_SUB: r_op = ALU_SUB;
      `FUNCT_AND: r_op = ALU_AND;
      `FUNCT_OR:  r_op = ALU_OR;
      `FUNCT_XOR: r_op = ALU_XOR;
      `FUNCT_SLT: r_op = ALU_SLT;
      `FUNCT_SLL: r_op = ALU_SLL;
      `FUNCT_SRL: r_op = ALU_SRL;
      default: begin
        funct_ok = 1'b0;
        r_op     = ALU_ADD;
      end
    endcase
  end

  always_comb begin
    ctrl = '0;
    case (instr.i.opcode)
      `OPCODE_R: begin
        ctrl.reg_write = funct_ok;
        ctrl.dst_rd    = funct_ok;
        ctrl.alu_op    = r_op;
      end
      `OPCODE_ADDI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = ALU_ADD;
      end
      `OPCODE_ORI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.zero_ext  = 1'b1;
        ctrl.alu_op    = ALU_OR;
      end
      `OPCODE_LW: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = ALU_ADD;
      end
      `OPCODE_SW: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = ALU_ADD;
      end
      // anything else is a no-op
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/register_file.sv
`default_nettype none

`include "cpu_consts.svh"

module register_file (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`REG_ADDR_WIDTH-1:0] rs,
  input  logic [`REG_ADDR_WIDTH-1:0] rt,
  output logic [`DATA_WIDTH-1:0]     rs_data,
  output logic [`DATA_WIDTH-1:0]     rt_data,
  input  logic                       write,
  input  logic [`REG_ADDR_WIDTH-1:0] write_reg,
  input  logic [`DATA_WIDTH-1:0]     write_data
);

  localparam int NUM_REGS = 1 << `REG_ADDR_WIDTH;

  logic [`DATA_WIDTH-1:0] regs [NUM_REGS];
  logic                   write_live;

  // r0 never takes a write
  assign write_live = write && (write_reg != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_live) begin
      regs[write_reg] <= write_data;
    end
  end

  // writeback in the same cycle shows through to decode
  assign rs_data = (write_live && write_reg == rs) ? write_data : regs[rs];
  assign rt_data = (write_live && write_reg == rt) ? write_data : regs[rt];

endmodule

`default_nettype wire

//--- hdl/hazard_unit.sv
`default_nettype none

`include "cpu_consts.svh"

module hazard_unit import cpu_pkg::*; (
  input  logic [`REG_ADDR_WIDTH-1:0] id_rs,
  input  logic [`REG_ADDR_WIDTH-1:0] id_rt,
  input  id_ex_t                     id_ex,
  input  ex_mem_t                    ex_mem,
  input  mem_wb_t                    mem_wb,
  output logic [1:0]                 forward_a,
  output logic [1:0]                 forward_b,
  output logic                       stall
);

  // a writer hits a reader unless the target is r0
  function automatic logic hit(
    input logic                       wr,
    input logic [`REG_ADDR_WIDTH-1:0] dst,
    input logic [`REG_ADDR_WIDTH-1:0] src
  );
    return wr && (dst != '0) && (dst == src);
  endfunction

  //////////////////////////////////////////////////
  // forwarding prefers the youngest producer

  assign forward_a = hit(ex_mem.ctrl.reg_write, ex_mem.dst, id_ex.rs) ? FWD_EX_MEM :
                     hit(mem_wb.reg_write, mem_wb.dst, id_ex.rs)      ? FWD_MEM_WB :
                                                                        FWD_REG;

  assign forward_b = hit(ex_mem.ctrl.reg_write, ex_mem.dst, id_ex.rt) ? FWD_EX_MEM :
                     hit(mem_wb.reg_write, mem_wb.dst, id_ex.rt)      ? FWD_MEM_WB :
                                                                        FWD_REG;

  //////////////////////////////////////////////////
  // load data is not ready until after MEM

  assign stall = id_ex.ctrl.mem_read &&
                 (hit(1'b1, id_ex.dst, id_rs) || hit(1'b1, id_ex.dst, id_rt));

endmodule

`default_nettype wire

//--- hdl/alu.sv
`default_nettype none

`include "cpu_consts.svh"

module alu import cpu_pkg::*; (
  input  alu_op_e                 op,
  input  logic [`DATA_WIDTH-1:0]  a,
  input  logic [`DATA_WIDTH-1:0]  b,
  input  logic [`SHAMT_WIDTH-1:0] shamt,
  output logic [`DATA_WIDTH-1:0]  result
);

  logic less;

  // signed compare for slt
  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLT: result = {{(`DATA_WIDTH-1){1'b0}}, less};
      // shifts act on rt, amount from the instruction
      ALU_SLL: result = b << shamt;
      ALU_SRL: result = b >> shamt;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/data_memory.sv
`default_nettype none

`include "cpu_consts.svh"

module data_memory (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`DATA_WIDTH-1:0] addr,
  input  logic                   write,
  input  logic [`DATA_WIDTH-1:0] wdata,
  output logic [`DATA_WIDTH-1:0] rdata
);

  localparam int DEPTH = 1 << `DMEM_DEPTH_LOG2;

  logic [`DATA_WIDTH-1:0]      mem [DEPTH];
  logic [`DMEM_DEPTH_LOG2-1:0] word;

  // byte address in, word index out, upper bits wrap
  assign word = addr[`DMEM_DEPTH_LOG2+1:2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (write) begin
      mem[word] <= wdata;
    end
  end

  assign rdata = mem[word];

  a_write_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(write)
  ) else $error("data memory write strobe unknown");

endmodule

`default_nettype wire

//--- hdl/processor.sv
`default_nettype none

`include "cpu_consts.svh"

module processor import cpu_pkg::*; (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        run,
  input  logic                        imem_write,
  input  logic [`IMEM_DEPTH_LOG2-1:0] imem_addr,
  input  logic [`INST_WIDTH-1:0]      imem_data,
  output logic                        mem_write,
  output logic [`DATA_WIDTH-1:0]      mem_addr,
  output logic [`DATA_WIDTH-1:0]      mem_wdata,
  output logic                        wb_valid,
  output logic [`REG_ADDR_WIDTH-1:0]  wb_reg,
  output logic [`DATA_WIDTH-1:0]      wb_data
);

  localparam int IMEM_DEPTH = 1 << `IMEM_DEPTH_LOG2;

  logic [`INST_WIDTH-1:0]      imem [IMEM_DEPTH];
  logic [`IMEM_DEPTH_LOG2-1:0] pc;

  instr_u  if_id_instr;
  logic    if_id_valid;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;

  ctrl_t                  dec_ctrl;
  id_ex_t                 id_ex_d;
  logic [`DATA_WIDTH-1:0] rs_data, rt_data;
  logic                   stall;
  logic [1:0]             forward_a, forward_b;
  logic [`DATA_WIDTH-1:0] opnd_a, opnd_b, alu_b, alu_result;
  logic [`DATA_WIDTH-1:0] load_data;

  //////////////////////////////////////////////////
  // fetch

  always_ff @(posedge clk) begin
    if (imem_write) begin
      imem[imem_addr] <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (run && !stall) begin
      pc <= pc + 1'b1;
    end
  end

  // idle fetch turns into a bubble
  always_ff @(posedge clk) begin
    if (reset) begin
      if_id_valid <= 1'b0;
    end else if (!stall) begin
      if_id_valid <= run;
      if_id_instr <= imem[pc];
    end
  end

  //////////////////////////////////////////////////
  // decode

  control_unit control_i (
    .instr (if_id_instr),
    .ctrl  (dec_ctrl)
  );

  register_file regs_i (
    .clk        (clk),
    .reset      (reset),
    .rs         (if_id_instr.r.rs),
    .rt         (if_id_instr.r.rt),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .write      (mem_wb.reg_write),
    .write_reg  (mem_wb.dst),
    .write_data (mem_wb.wdata)
  );

  hazard_unit hazard_i (
    .id_rs     (if_id_instr.r.rs),
    .id_rt     (if_id_instr.r.rt),
    .id_ex     (id_ex),
    .ex_mem    (ex_mem),
    .mem_wb    (mem_wb),
    .forward_a (forward_a),
    .forward_b (forward_b),
    .stall     (stall)
  );

  always_comb begin
    id_ex_d.ctrl    = (if_id_valid && !stall) ? dec_ctrl : '0;
    id_ex_d.rs      = if_id_instr.r.rs;
    id_ex_d.rt      = if_id_instr.r.rt;
    id_ex_d.dst     = dec_ctrl.dst_rd ? if_id_instr.r.rd : if_id_instr.i.rt;
    id_ex_d.rs_data = rs_data;
    id_ex_d.rt_data = rt_data;
    // ori zero-extends and everything else sign-extends
    id_ex_d.imm     = dec_ctrl.zero_ext ?
                      {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, if_id_instr.i.imm} :
                      {{(`DATA_WIDTH-`IMM_WIDTH){if_id_instr.i.imm[`IMM_WIDTH-1]}},
                       if_id_instr.i.imm};
    id_ex_d.shamt   = if_id_instr.r.shamt;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex.ctrl <= '0;
    end else begin
      id_ex <= id_ex_d;
    end
  end

  //////////////////////////////////////////////////
  // execute

  always_comb begin
    case (forward_a)
      FWD_EX_MEM: opnd_a = ex_mem.alu_result;
      FWD_MEM_WB: opnd_a = mem_wb.wdata;
      default:    opnd_a = id_ex.rs_data;
    endcase
    case (forward_b)
      FWD_EX_MEM: opnd_b = ex_mem.alu_result;
      FWD_MEM_WB: opnd_b = mem_wb.wdata;
      default:    opnd_b = id_ex.rt_data;
    endcase
  end

  assign alu_b = id_ex.ctrl.alu_src ? id_ex.imm : opnd_b;

  alu alu_i (
    .op     (id_ex.ctrl.alu_op),
    .a      (opnd_a),
    .b      (alu_b),
    .shamt  (id_ex.shamt),
    .result (alu_result)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.ctrl <= '0;
    end else begin
      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.dst        <= id_ex.dst;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= opnd_b;
    end
  end

  //////////////////////////////////////////////////
  // memory and writeback

  data_memory dmem_i (
    .clk   (clk),
    .reset (reset),
    .addr  (ex_mem.alu_result),
    .write (ex_mem.ctrl.mem_write),
    .wdata (ex_mem.store_data),
    .rdata (load_data)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb.reg_write <= 1'b0;
    end else begin
      mem_wb.reg_write <= ex_mem.ctrl.reg_write;
      mem_wb.dst       <= ex_mem.dst;
      mem_wb.wdata     <= ex_mem.ctrl.mem_read ? load_data : ex_mem.alu_result;
    end
  end

  assign mem_write = ex_mem.ctrl.mem_write;
  assign mem_addr  = ex_mem.alu_result;
  assign mem_wdata = ex_mem.store_data;

  assign wb_valid = mem_wb.reg_write && (mem_wb.dst != '0);
  assign wb_reg   = mem_wb.dst;
  assign wb_data  = mem_wb.wdata;

  a_mem_op_onehot: assert property (
    @(posedge clk) disable iff (reset) !(ex_mem.ctrl.mem_read && ex_mem.ctrl.mem_write)
  ) else $error("load and store both set in memory stage");

  // the bubble behind a stalled load clears the hazard
  a_stall_one_cycle: assert property (
    @(posedge clk) disable iff (reset) stall |=> !stall
  ) else $error("load-use stall held for more than one cycle");

endmodule

`default_nettype wire

//--- test/processor_tb.sv
`default_nettype none

`include "cpu_consts.svh"

module processor_tb;

  localparam int PROG_LEN     = 60;
  localparam int DIRECTED_LEN = 11;
  localparam int IMEM_WORDS   = 1 << `IMEM_DEPTH_LOG2;
  localparam int DMEM_WORDS   = 1 << `DMEM_DEPTH_LOG2;
  localparam int DRAIN_LIMIT  = 500;
  localparam int IDLE_CYCLES  = 20;

  // the core does not decode this opcode and runs it as a no-op
  localparam logic [`OPCODE_WIDTH-1:0] NOP_OPCODE = 6'h3f;

  typedef struct packed {
    logic [`REG_ADDR_WIDTH-1:0] dst;
    logic [`DATA_WIDTH-1:0]     data;
  } wb_entry_t;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] data;
  } store_entry_t;

  logic                        clk;
  logic                        reset;
  logic                        run;
  logic                        imem_write;
  logic [`IMEM_DEPTH_LOG2-1:0] imem_addr;
  logic [`INST_WIDTH-1:0]      imem_data;
  logic                        mem_write;
  logic [`DATA_WIDTH-1:0]      mem_addr;
  logic [`DATA_WIDTH-1:0]      mem_wdata;
  logic                        wb_valid;
  logic [`REG_ADDR_WIDTH-1:0]  wb_reg;
  logic [`DATA_WIDTH-1:0]      wb_data;

  logic [`INST_WIDTH-1:0] prog [PROG_LEN];
  logic [31:0]            rand_state;
  wb_entry_t              exp_wb [$];
  store_entry_t           exp_st [$];

  int wb_total;
  int st_total;
  int wb_seen      = 0;
  int st_seen      = 0;
  int wb_errors    = 0;
  int st_errors    = 0;
  int pulse_errors = 0;
  int run_errors   = 0;

  processor dut_i (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .imem_write (imem_write),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // program generation

  function automatic logic [`INST_WIDTH-1:0] r_format(
    input logic [5:0] funct,
    input logic [4:0] rd,
    input logic [4:0] rs,
    input logic [4:0] rt,
    input logic [4:0] shamt
  );
    return {`OPCODE_R, rs, rt, rd, shamt, funct};
  endfunction

  function automatic logic [`INST_WIDTH-1:0] i_format(
    input logic [5:0]  opcode,
    input logic [4:0]  rt,
    input logic [4:0]  rs,
    input logic [15:0] imm
  );
    return {opcode, rs, rt, imm};
  endfunction

  // unused words carry their own address
  function automatic logic [`INST_WIDTH-1:0] fill_word(input logic [7:0] addr);
    return {NOP_OPCODE, 18'h0, addr};
  endfunction

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rand_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rand_state = x;
    return x;
  endfunction

  function automatic logic [`INST_WIDTH-1:0] random_instr();
    logic [31:0]            r;
    logic [31:0]            s;
    logic [4:0]             rs;
    logic [4:0]             rt;
    logic [4:0]             rd;
    logic [4:0]             base;
    logic [5:0]             funct;
    logic [15:0]            offset;
    logic [`INST_WIDTH-1:0] word;
    r = next_rand();
    s = next_rand();
    // r0..r7 only so that neighbours collide often
    rs = {2'b00, r[2:0]};
    rt = {2'b00, r[5:3]};
    rd = {2'b00, r[8:6]};
    // r0 base keeps addresses small
    // negative offsets wrap the index
    base   = r[12] ? 5'd0 : rs;
    offset = {{9{s[20]}}, s[20:16], 2'b00};
    case (r[11:9])
      3'd0:    funct = `FUNCT_ADD;
      3'd1:    funct = `FUNCT_SUB;
      3'd2:    funct = `FUNCT_AND;
      3'd3:    funct = `FUNCT_OR;
      3'd4:    funct = `FUNCT_XOR;
      3'd5:    funct = `FUNCT_SLT;
      3'd6:    funct = `FUNCT_SLL;
      default: funct = `FUNCT_SRL;
    endcase
    case (r[31:28])
      4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: word = r_format(funct, rd, rs, rt, s[25:21]);
      4'd6, 4'd7:        word = i_format(`OPCODE_ADDI, rt, rs, s[15:0]);
      4'd8, 4'd9:        word = i_format(`OPCODE_ORI, rt, rs, s[15:0]);
      4'd10, 4'd11, 4'd12: word = i_format(`OPCODE_LW, rt, base, offset);
      default:           word = i_format(`OPCODE_SW, rt, base, offset);
    endcase
    return word;
  endfunction

  function automatic void build_program();
    // directed opening for extension, forwarding, load-use, r0 and index wrap
    prog[0] = i_format(`OPCODE_ADDI, 5'd1, 5'd0, 16'hfffb);
    prog[1] = i_format(`OPCODE_ORI, 5'd2, 5'd0, 16'hfff0);
    prog[2] = r_format(`FUNCT_ADD, 5'd3, 5'd1, 5'd2, 5'd0);
    prog[3] = r_format(`FUNCT_SUB, 5'd4, 5'd3, 5'd1, 5'd0);
    prog[4] = i_format(`OPCODE_SW, 5'd4, 5'd0, 16'h0008);
    prog[5] = i_format(`OPCODE_LW, 5'd5, 5'd0, 16'h0008);
    prog[6] = r_format(`FUNCT_ADD, 5'd6, 5'd5, 5'd5, 5'd0);
    prog[7] = r_format(`FUNCT_ADD, 5'd0, 5'd6, 5'd6, 5'd0);
    prog[8] = r_format(`FUNCT_OR, 5'd7, 5'd0, 5'd1, 5'd0);
    prog[9] = i_format(`OPCODE_SW, 5'd7, 5'd0, 16'hfffc);
    // same word as the store above once the index wraps
    prog[10] = i_format(`OPCODE_LW, 5'd1, 5'd0, 16'h03fc);
    for (int i = DIRECTED_LEN; i < PROG_LEN; i++) begin
      prog[i] = random_instr();
    end
  endfunction

  //////////////////////////////////////////////////
  // reference model runs prog in order

  function automatic void model_run();
    logic [31:0]  regs [32];
    logic [31:0]  dmem [DMEM_WORDS];
    logic [31:0]  ins;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  simm;
    logic [31:0]  zimm;
    logic [31:0]  addr;
    logic [31:0]  res;
    logic [5:0]   opcode;
    logic [5:0]   funct;
    logic [4:0]   rs;
    logic [4:0]   rt;
    logic [4:0]   rd;
    logic [4:0]   shamt;
    logic [4:0]   dst;
    logic         wr;
    wb_entry_t    wb;
    store_entry_t st;
    for (int i = 0; i < 32; i++) begin
      regs[i] = 32'h0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'h0;
    end
    exp_wb.delete();
    exp_st.delete();
    for (int pc = 0; pc < PROG_LEN; pc++) begin
      ins    = prog[pc];
      opcode = ins[31:26];
      rs     = ins[25:21];
      rt     = ins[20:16];
      rd     = ins[15:11];
      shamt  = ins[10:6];
      funct  = ins[5:0];
      a      = regs[rs];
      b      = regs[rt];
      simm   = {{16{ins[15]}}, ins[15:0]};
      zimm   = {16'h0, ins[15:0]};
      wr     = 1'b0;
      dst    = rt;
      res    = 32'h0;
      case (opcode)
        `OPCODE_R: begin
          wr  = 1'b1;
          dst = rd;
          case (funct)
            `FUNCT_ADD: res = a + b;
            `FUNCT_SUB: res = a - b;
            `FUNCT_AND: res = a & b;
            `FUNCT_OR:  res = a | b;
            `FUNCT_XOR: res = a ^ b;
            `FUNCT_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `FUNCT_SLL: res = b << shamt;
            `FUNCT_SRL: res = b >> shamt;
            default:    wr = 1'b0;
          endcase
        end
        `OPCODE_ADDI: begin
          wr  = 1'b1;
          res = a + simm;
        end
        `OPCODE_ORI: begin
          wr  = 1'b1;
          res = a | zimm;
        end
        `OPCODE_LW: begin
          addr = a + simm;
          wr   = 1'b1;
          res  = dmem[addr[9:2]];
        end
        `OPCODE_SW: begin
          addr             = a + simm;
          dmem[addr[9:2]] = b;
          st.addr          = addr;
          st.data          = b;
          exp_st.push_back(st);
        end
        default: wr = 1'b0;
      endcase
      if (wr && dst != 5'd0) begin
        regs[dst] = res;
        wb.dst    = dst;
        wb.data   = res;
        exp_wb.push_back(wb);
      end
    end
  endfunction

  //////////////////////////////////////////////////
  // comparison sampled mid-cycle

  always @(negedge clk) begin : compare
    wb_entry_t    wb_exp;
    store_entry_t st_exp;
    if (!reset) begin
      if (!run) begin
        assert (!wb_valid && !mem_write) else begin
          pulse_errors++;
          $display("t=%0t: writeback or store pulse while run is low", $time);
        end
      end
      if (wb_valid) begin
        wb_seen++;
        if (exp_wb.size() == 0) begin
          pulse_errors++;
          $display("t=%0t: writeback to r%0d beyond the end of the program", $time, wb_reg);
        end else begin
          wb_exp = exp_wb.pop_front();
          assert (wb_reg == wb_exp.dst) else begin
            wb_errors++;
            $display("[FAIL] t=%0t wb_reg: got %0d, expected %0d", $time, wb_reg, wb_exp.dst);
          end
          assert (wb_data == wb_exp.data) else begin
            wb_errors++;
            $display("[FAIL] t=%0t wb_data: got %h, expected %h", $time, wb_data, wb_exp.data);
          end
        end
      end
      if (mem_write) begin
        st_seen++;
        if (exp_st.size() == 0) begin
          pulse_errors++;
          $display("t=%0t: store to %h beyond the end of the program", $time, mem_addr);
        end else begin
          st_exp = exp_st.pop_front();
          assert (mem_addr == st_exp.addr) else begin
            st_errors++;
            $display("[FAIL] t=%0t mem_addr: got %h, expected %h", $time, mem_addr, st_exp.addr);
          end
          assert (mem_wdata == st_exp.data) else begin
            st_errors++;
            $display("[FAIL] t=%0t mem_wdata: got %h, expected %h",
                     $time, mem_wdata, st_exp.data);
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus

  initial begin : stimulus
    int cycles;
    reset      = 1'b1;
    run        = 1'b0;
    imem_write = 1'b0;
    imem_addr  = '0;
    imem_data  = '0;
    rand_state = 32'h3b81_5143;
    build_program();
    model_run();
    wb_total = exp_wb.size();
    st_total = exp_st.size();

    // load every word while reset spans the first three rising edges
    for (int i = 0; i < IMEM_WORDS; i++) begin
      @(negedge clk);
      if (i == 2) begin
        reset <= 1'b0;
      end
      imem_write <= 1'b1;
      imem_addr  <= i[`IMEM_DEPTH_LOG2-1:0];
      imem_data  <= (i < PROG_LEN) ? prog[i] : fill_word(i[7:0]);
    end
    @(negedge clk);
    imem_write <= 1'b0;
    run        <= 1'b1;

    cycles = 0;
    while ((wb_seen < wb_total || st_seen < st_total) && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (wb_seen < wb_total || st_seen < st_total) begin
      run_errors++;
      $display("timeout: after %0d cycles only %0d of %0d writebacks and %0d of %0d stores",
               DRAIN_LIMIT, wb_seen, wb_total, st_seen, st_total);
    end

    // quiet tail where any late pulse is an extra one
    @(negedge clk);
    run <= 1'b0;
    repeat (IDLE_CYCLES) @(posedge clk);

    assert (wb_seen == wb_total) else begin
      run_errors++;
      $display("writeback count wrong: %0d seen, %0d expected", wb_seen, wb_total);
    end
    assert (st_seen == st_total) else begin
      run_errors++;
      $display("store count wrong: %0d seen, %0d expected", st_seen, st_total);
    end

    $display("errors: writeback %0d, store %0d, pulse %0d, run %0d",
             wb_errors, st_errors, pulse_errors, run_errors);
    if (wb_errors + st_errors + pulse_errors + run_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/hazard_unit.sv
hdl/alu.sv
hdl/data_memory.sv
hdl/processor.sv
test/processor_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f verilog.f --top-module processor_tb

./obj_dir/Vprocessor_tb > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

exit 0
